// ==== bench/sram_responder.sv ====
module sram_responder (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              sram_req,
    input  rsz_pkg::wr_req_t  sram_wr,
    input  logic              hold,               // Keep ack low while set
    input  int                ack_delay,          // Cycles from req seen to ack
    output logic              sram_ack,
    output logic              wr_done,            // One cycle per completed write
    output rsz_pkg::wr_req_t  done_wr             // Write that just completed
);

    timeunit 1ns;
    timeprecision 100ps;

    rsz_pkg::wr_req_t seen;                       // Captured when ack rises
    int               waited;

    // Acts 5 ns after each rising edge, as the stimulus does
    initial begin
        sram_ack = 1'b0;
        wr_done  = 1'b0;
        done_wr  = '0;
        seen     = '0;
        waited   = 0;
        forever begin
            @(posedge clk);
            #5;
            wr_done = 1'b0;
            if (!rst_n) begin
                sram_ack = 1'b0;
                waited   = 0;
            end else if (sram_req && !sram_ack && !hold) begin
                if (waited >= ack_delay) begin
                    sram_ack = 1'b1;              // Phase 2, data sampled here
                    seen     = sram_wr;
                    waited   = 0;
                end else begin
                    waited++;
                end
            end else if (!sram_req && sram_ack) begin
                sram_ack = 1'b0;                  // Phase 4 closes the write
                wr_done  = 1'b1;
                done_wr  = seen;
            end
        end
    end

endmodule

// ==== bench/tb_image_resizer.sv ====
module tb_image_resizer;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SRC_W      = 8;
    localparam int SRC_H      = 6;
    localparam int BLK_W      = 4;
    localparam int BLK_H      = 3;
    localparam int FIFO_DEPTH = 2;
    localparam int OUT_W      = SRC_W / BLK_W;
    localparam int N_BLK      = OUT_W * (SRC_H / BLK_H);
    localparam int BLK_PIX    = BLK_W * BLK_H;            // Divisor of the box average
    localparam int FRAME_PIX  = SRC_W * SRC_H;
    localparam int PART_PIX   = 17;                       // Stops before block 0 closes
    localparam int AW         = rsz_pkg::ADDR_W;
    localparam int N_CASES    = 7;
    localparam int MAX_GAP    = 3;
    localparam int MAX_DLY    = 6;
    localparam int DRAIN_CYC  = N_BLK * (rsz_pkg::SUM_W + MAX_DLY + 8);
    localparam int CASE_CYC   = 2 * FRAME_PIX * (1 + MAX_GAP) + DRAIN_CYC + 8;
    localparam int LIMIT      = 2 * (N_CASES * CASE_CYC + 3);
    localparam int PAT_CONST  = 0;
    localparam int PAT_RAND   = 1;

    typedef struct packed {
        int   kind;                                   // PAT_CONST or PAT_RAND
        int   value;                                  // Grey level for PAT_CONST
        int   gap;                                    // Max idle cycles after a pixel
        int   dly;                                    // Max ack delay
        logic restart;                                // Partial frame cut by a new sof
        logic hold;                                   // Ack withheld over two frames
        logic exp_ovr;                                // Overrun at the end of the case
    } case_t;

    logic              clk;
    logic              rst_n;
    logic              pix_valid;
    rsz_pkg::pix_in_t  pix;
    logic              sram_req;
    rsz_pkg::wr_req_t  sram_wr;
    logic              sram_ack;
    logic              overrun;
    logic              hold;
    int                ack_delay;
    logic              wr_done;
    rsz_pkg::wr_req_t  done_wr;

    case_t             cases [N_CASES];
    rsz_pkg::wr_req_t  exp_tab [N_CASES * N_BLK];    // Expected writes in order
    int                n_exp;                         // Filled by the stimulus
    int                n_got;                         // Advanced by the checker
    int                cur_dly_max;
    logic [31:0]       pix_rng;
    logic [31:0]       ack_rng;
    int                write_errs;
    int                flag_errs;
    int                missing_errs;
    int                cycles;

    image_resizer #(
        .SRC_W      (SRC_W),
        .SRC_H      (SRC_H),
        .BLK_W      (BLK_W),
        .BLK_H      (BLK_H),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) image_resizer_inst (.*);

    sram_responder sram_responder_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                       // 40 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;                                       // Back to the drive point
        end
    endtask

    task automatic drive_pixel(input logic [7:0] v, input logic sof);
        pix_valid = 1'b1;
        pix.color = v;
        pix.sof   = sof;
        wait_cycles(1);
        pix_valid = 1'b0;
        pix.sof   = 1'b0;
    endtask

    // Sends n pixels in raster order and models the block averages
    task automatic send_frame(input case_t c, input int n, input logic record);
        int         sums [N_BLK];
        int         i;
        int         row;
        int         col;
        int         b;
        logic [7:0] v;
        for (i = 0; i < N_BLK; i++) sums[i] = 0;
        for (i = 0; i < n; i++) begin
            row = i / SRC_W;
            col = i % SRC_W;
            b   = (row / BLK_H) * OUT_W + col / BLK_W;
            if (c.kind == PAT_RAND) begin
                pix_rng = xorshift32(pix_rng);
                v       = pix_rng[7:0];
            end else begin
                v = 8'(c.value);
            end
            sums[b] += int'(v);
            drive_pixel(v, i == 0);                   // First pixel carries sof
            if (record && col % BLK_W == BLK_W - 1 && row % BLK_H == BLK_H - 1) begin
                exp_tab[n_exp] = '{addr: AW'(b), data: 8'(sums[b] / BLK_PIX)};
                n_exp++;
            end
            if (c.gap > 0) begin
                pix_rng = xorshift32(pix_rng);
                wait_cycles(int'(pix_rng % 32'(c.gap + 1)));
            end
        end
    endtask

    task automatic wait_drain(input int k);
        int waited;
        waited = 0;
        while (n_got < n_exp && waited < DRAIN_CYC) begin
            wait_cycles(1);
            waited++;
        end
        if (n_got < n_exp) begin
            missing_errs += n_exp - n_got;
            $display("Case %0d ended with %0d write(s) still missing", k, n_exp - n_got);
        end
        wait_cycles(4);                               // Writer back in idle
    endtask

    task automatic check_write(input rsz_pkg::wr_req_t got, input rsz_pkg::wr_req_t exp);
        if (got !== exp) begin
            write_errs++;
            $display("FAIL %0t: write addr %0d data %0d, expected addr %0d data %0d",
                     $time, got.addr, got.data, exp.addr, exp.data);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errs++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Compares each completed write and picks the next ack delay
    always @(posedge clk) begin
        if (!rst_n) begin
            ack_rng    = 32'h3a49;
            ack_delay  = 0;
            n_got      = 0;
            write_errs = 0;
        end else if (wr_done) begin
            if (n_got < n_exp) begin
                check_write(done_wr, exp_tab[n_got]);
                n_got++;
            end else begin
                write_errs++;
                $display("Write to address %0d at %0t came with none expected",
                         done_wr.addr, $time);
            end
            ack_rng   = xorshift32(ack_rng);
            ack_delay = int'(ack_rng % 32'(cur_dly_max + 1));
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: the run hung and did not end within %0d cycles", LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        case_t c;
        int    k;
        cases[0] = '{PAT_CONST, 90,  0, 0, 1'b0, 1'b0, 1'b0};              // Flat grey
        cases[1] = '{PAT_RAND,  0,   0, 0, 1'b0, 1'b0, 1'b0};
        cases[2] = '{PAT_CONST, 255, 0, 2, 1'b0, 1'b0, 1'b0};              // Largest sum
        cases[3] = '{PAT_CONST, 0,   0, 2, 1'b0, 1'b0, 1'b0};
        cases[4] = '{PAT_RAND,  0,   MAX_GAP, MAX_DLY, 1'b0, 1'b0, 1'b0};  // Gaps, slow SRAM
        cases[5] = '{PAT_RAND,  0,   1, 3, 1'b1, 1'b0, 1'b0};              // sof mid-frame
        cases[6] = '{PAT_RAND,  0,   0, 0, 1'b0, 1'b1, 1'b1};              // Sums lost
        rst_n        = 1'b0;
        pix_valid    = 1'b0;
        pix          = '0;
        hold         = 1'b0;
        pix_rng      = 32'h3a49;
        n_exp        = 0;
        flag_errs    = 0;
        missing_errs = 0;
        cur_dly_max  = 0;
        wait_cycles(3);
        rst_n = 1'b1;
        check_flag(overrun, 1'b0, "overrun after reset");
        check_flag(sram_req, 1'b0, "sram_req after reset");
        for (k = 0; k < N_CASES; k++) begin
            c           = cases[k];
            cur_dly_max = c.dly;
            hold        = c.hold;
            if (c.restart) send_frame(c, PART_PIX, 1'b0);
            send_frame(c, FRAME_PIX, 1'b1);
            if (c.hold) begin
                wait_cycles(4);
                send_frame(c, FRAME_PIX, 1'b0);   // FIFO full, every push dropped
                wait_cycles(4);
                hold = 1'b0;
            end
            wait_drain(k);
            check_flag(overrun, c.exp_ovr, "overrun at end of case");
        end
        $display("Errors: %0d bad writes, %0d bad flags, %0d missing writes",
                 write_errs, flag_errs, missing_errs);
        if (write_errs + flag_errs + missing_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
source/rsz_pkg.sv
source/block_accumulator.sv
source/sum_fifo.sv
source/avg_divider.sv
source/sram_writer.sv
source/image_resizer.sv
bench/sram_responder.sv
bench/tb_image_resizer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module tb_image_resizer \
    -f filelist.f -o tb_image_resizer > build.log 2>&1 \
    && ./obj_dir/tb_image_resizer > sim.log 2>&1 \
    && grep -qF '*** TEST PASSED ***' sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// ==== source/avg_divider.sv ====
module avg_divider #(
    parameter int BLK_W = 40,                     // Block width
    parameter int BLK_H = 30                      // Block height
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               head_valid,
    input  rsz_pkg::blk_sum_t  head,
    output logic               pop,               // Head taken this cycle
    output logic               res_valid,         // Held until take
    output rsz_pkg::wr_req_t   res,
    input  logic               take
);

    localparam int SW  = rsz_pkg::SUM_W;
    localparam int PXW = $bits(rsz_pkg::pixel_t);
    localparam int DIV = BLK_W * BLK_H;           // Pixels per block
    localparam int NW  = $clog2(SW + 1);

    logic          busy;
    logic [NW-1:0] step;                          // Counts 0..SW, SW is the finish cycle
    logic [SW-1:0] rem;                           // Partial remainder
    logic [SW-1:0] quo;                           // Dividend shifts out, quotient shifts in
    logic [SW:0]   shifted;
    logic [SW:0]   diff;

    assign pop = head_valid && !busy && !res_valid;   // Only from idle

    always_comb begin
        shifted = {rem, quo[SW-1]};               // Bring down next dividend bit
        diff    = shifted - (SW + 1)'(DIV);       // MSB set means it did not fit
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            step      <= '0;
            res_valid <= 1'b0;
        end else if (pop) begin
            busy <= 1'b1;
            step <= '0;
        end else if (busy) begin
            step <= step + 1'b1;
            if (step == NW'(SW)) begin            // Quotient complete last edge
                busy      <= 1'b0;
                res_valid <= 1'b1;
            end
        end else if (take) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rem      <= '0;
            quo      <= head.sum;
            res.addr <= head.addr;                // Address rides along
        end else if (busy) begin
            if (step != NW'(SW)) begin
                if (diff[SW]) begin               // Restore, quotient bit 0
                    rem <= shifted[SW-1:0];
                    quo <= {quo[SW-2:0], 1'b0};
                end else begin
                    rem <= diff[SW-1:0];
                    quo <= {quo[SW-2:0], 1'b1};
                end
            end else begin
                res.data <= quo[PXW-1:0];         // Average is at most 255
            end
        end
    end

endmodule

// ==== source/block_accumulator.sv ====
module block_accumulator #(
    parameter int SRC_W = 1280,                   // Source frame width
    parameter int SRC_H = 960,                    // Source frame height
    parameter int BLK_W = 40,                     // Block width
    parameter int BLK_H = 30                      // Block height
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pix_valid,         // No back-pressure
    input  rsz_pkg::pix_in_t   pix,
    output logic               blk_valid,         // One-cycle push
    output rsz_pkg::blk_sum_t  blk
);

    localparam int OUT_W = SRC_W / BLK_W;         // Blocks per line
    localparam int OUT_H = SRC_H / BLK_H;         // Block rows per frame
    localparam int SW    = rsz_pkg::SUM_W;
    localparam int AW    = rsz_pkg::ADDR_W;
    localparam int ICW   = (BLK_W > 1) ? $clog2(BLK_W) : 1;
    localparam int IRW   = (BLK_H > 1) ? $clog2(BLK_H) : 1;
    localparam int BCW   = (OUT_W > 1) ? $clog2(OUT_W) : 1;
    localparam int BRW   = (OUT_H > 1) ? $clog2(OUT_H) : 1;

    logic [ICW-1:0] in_col;                       // Column inside the block
    logic [IRW-1:0] in_row;                       // Line inside the block row
    logic [BCW-1:0] blk_col;                      // Block column
    logic [BRW-1:0] blk_row;                      // Block row
    logic           running;                      // Set by sof, cleared at frame end

    logic [SW-1:0]  psum [OUT_W];                 // One running sum per block column

    logic [ICW-1:0] cur_ic;                       // Position of the pixel on the bus
    logic [IRW-1:0] cur_ir;
    logic [BCW-1:0] cur_bc;
    logic [BRW-1:0] cur_br;
    logic           accept;
    logic           ic_wrap;
    logic           bc_wrap;
    logic           ir_wrap;
    logic           br_wrap;
    logic           first_px;
    logic           last_px;
    logic [SW-1:0]  new_sum;
    logic [AW-1:0]  cur_addr;

    always_comb begin
        // A sof pixel sits at 0,0 whatever the counters say
        cur_ic   = pix.sof ? '0 : in_col;
        cur_ir   = pix.sof ? '0 : in_row;
        cur_bc   = pix.sof ? '0 : blk_col;
        cur_br   = pix.sof ? '0 : blk_row;
        accept   = pix_valid && (running || pix.sof);    // Drop pixels before first sof
        ic_wrap  = cur_ic == ICW'(BLK_W - 1);
        bc_wrap  = cur_bc == BCW'(OUT_W - 1);
        ir_wrap  = cur_ir == IRW'(BLK_H - 1);
        br_wrap  = cur_br == BRW'(OUT_H - 1);
        first_px = (cur_ic == '0) && (cur_ir == '0);     // Block opens here
        last_px  = ic_wrap && ir_wrap;                   // Block closes here
        new_sum  = (first_px ? '0 : psum[cur_bc]) + SW'(pix.color);
        cur_addr = AW'(cur_br) * AW'(OUT_W) + AW'(cur_bc);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_col  <= '0;
            in_row  <= '0;
            blk_col <= '0;
            blk_row <= '0;
            running <= 1'b0;
        end else if (accept) begin
            in_col  <= cur_ic + 1'b1;              // Default is one step right
            in_row  <= cur_ir;
            blk_col <= cur_bc;
            blk_row <= cur_br;
            running <= !(last_px && bc_wrap && br_wrap);  // Idle after the last pixel
            if (ic_wrap) begin
                in_col  <= '0;
                blk_col <= cur_bc + 1'b1;
                if (bc_wrap) begin                 // End of a source line
                    blk_col <= '0;
                    in_row  <= cur_ir + 1'b1;
                    if (ir_wrap) begin             // End of a block row
                        in_row  <= '0;
                        blk_row <= br_wrap ? '0 : cur_br + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk_valid <= 1'b0;
        end else begin
            blk_valid <= accept && last_px;        // Pulse after the closing pixel
        end
    end

    // Partial sums and the result word
    always_ff @(posedge clk) begin
        if (accept) begin
            psum[cur_bc] <= new_sum;
            if (last_px) begin
                blk.sum  <= new_sum;
                blk.addr <= cur_addr;
            end
        end
    end

endmodule

// ==== source/image_resizer.sv ====
module image_resizer #(
    parameter int SRC_W      = 1280,              // Source frame width
    parameter int SRC_H      = 960,               // Source frame height
    parameter int BLK_W      = 40,                // 1280 / 32
    parameter int BLK_H      = 30,                // 960 / 32
    parameter int FIFO_DEPTH = 4                  // Block sums waiting for the divider
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pix_valid,
    input  rsz_pkg::pix_in_t   pix,
    output logic               sram_req,
    output rsz_pkg::wr_req_t   sram_wr,
    input  logic               sram_ack,
    output logic               overrun            // Block sum was lost
);

    logic               blk_valid;
    rsz_pkg::blk_sum_t  blk;
    logic               head_valid;
    rsz_pkg::blk_sum_t  head;
    logic               pop;
    logic               res_valid;
    rsz_pkg::wr_req_t   res;
    logic               take;

    block_accumulator #(
        .SRC_W (SRC_W),
        .SRC_H (SRC_H),
        .BLK_W (BLK_W),
        .BLK_H (BLK_H)
    ) block_accumulator_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix       (pix),
        .blk_valid (blk_valid),
        .blk       (blk)
    );

    sum_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) sum_fifo_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (blk_valid),
        .din        (blk),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop),
        .overrun    (overrun)
    );

    avg_divider #(
        .BLK_W (BLK_W),
        .BLK_H (BLK_H)
    ) avg_divider_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop),
        .res_valid  (res_valid),
        .res        (res),
        .take       (take)
    );

    sram_writer sram_writer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_valid (res_valid),
        .res       (res),
        .take      (take),
        .sram_req  (sram_req),
        .sram_wr   (sram_wr),
        .sram_ack  (sram_ack)
    );

endmodule

// ==== source/rsz_pkg.sv ====
package rsz_pkg;

    localparam int SUM_W  = 20;                   // Block sum width, 4096 pixels at 255
    localparam int ADDR_W = 10;                   // Output index width, up to 1024 pixels

    typedef logic [7:0] pixel_t;                  // One grey pixel

    // Incoming pixel beat, sof flags the first pixel of a frame
    typedef struct packed {
        pixel_t color;                            // Grey value
        logic   sof;                              // Start of frame
    } pix_in_t;

    // Finished block, raw sum plus its output index
    typedef struct packed {
        logic [ADDR_W-1:0] addr;                  // Row times OUT_W plus column
        logic [SUM_W-1:0]  sum;                   // Sum of all block pixels
    } blk_sum_t;

    // One SRAM write
    typedef struct packed {
        logic [ADDR_W-1:0] addr;                  // SRAM word address
        pixel_t            data;                  // Averaged pixel
    } wr_req_t;

endpackage

// ==== source/sram_writer.sv ====
module sram_writer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               res_valid,
    input  rsz_pkg::wr_req_t   res,
    output logic               take,              // Result accepted this cycle
    output logic               sram_req,
    output rsz_pkg::wr_req_t   sram_wr,           // Stable while req is high
    input  logic               sram_ack
);

    typedef enum logic [1:0] {
        ST_IDLE,                                  // Free, ack already low
        ST_REQ,                                   // req high, wait for ack
        ST_REL                                    // req dropped, wait for ack low
    } state_t;

    state_t state;

    assign take     = (state == ST_IDLE) && res_valid && !sram_ack;
    assign sram_req = state == ST_REQ;            // Straight from the state flops

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (take)      state <= ST_REQ;
                ST_REQ:  if (sram_ack)  state <= ST_REL;
                ST_REL:  if (!sram_ack) state <= ST_IDLE;   // Write complete
                default:                state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) sram_wr <= res;                 // Latch write for the whole cycle
    end

endmodule

// ==== source/sum_fifo.sv ====
module sum_fifo #(
    parameter int FIFO_DEPTH = 4                  // Waiting block sums
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,              // From the accumulator, no ready
    input  rsz_pkg::blk_sum_t  din,
    output logic               head_valid,
    output rsz_pkg::blk_sum_t  head,
    input  logic               pop,               // Removes head this edge
    output logic               overrun            // Sticky until reset
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    rsz_pkg::blk_sum_t mem [FIFO_DEPTH];
    logic [PW-1:0]     wr_ptr;
    logic [PW-1:0]     rd_ptr;
    logic [CW-1:0]     count;
    logic              full;
    logic              do_push;
    logic              do_pop;

    // Wrap that also works for depths that are not a power of two
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full       = count == CW'(FIFO_DEPTH);
    assign head_valid = count != '0;
    assign head       = mem[rd_ptr];              // Read straight from the array
    assign do_push    = push && !full;            // Push while full is lost
    assign do_pop     = pop && head_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // Both or neither
            endcase
            if (push && full) overrun <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= din;
    end

endmodule
